/* verilog/ring_reader_cfg.svh */
`ifndef RING_READER_CFG_SVH
`define RING_READER_CFG_SVH

// Width of one cache line read from the host ring
`define RR_LINE_BITS 64

// Width of a line address in host memory
`define RR_ADDR_BITS 32

// Ring index width, which gives a ring of 16 lines
`define RR_RING_IDX_BITS 4

// Reads that may be outstanding at once in the reorder scoreboard
`define RR_SB_ENTRIES 8

`endif

/* verilog/mem_if_pkg.sv */
`include "ring_reader_cfg.svh"

// ==================================================
// Host memory request and response types
// ==================================================

package mem_if_pkg;

    // One cache line of payload
    typedef logic [`RR_LINE_BITS-1:0] line_data_t;

    // Line address in host memory
    typedef logic [`RR_ADDR_BITS-1:0] line_addr_t;

    // The reorder tag must be able to name every scoreboard slot
    localparam int ROB_TAG_BITS = $clog2(`RR_SB_ENTRIES);

    // Metadata sent with each read request.  Memory hands the same
    // value back with the response, so the tag tells where the line
    // belongs and is_header marks traffic owned by another client
    typedef struct packed {
        logic                    is_header;
        logic [ROB_TAG_BITS-1:0] rob_tag;
    } read_mdata_t;

endpackage

/* verilog/ring_pkg.sv */
`include "ring_reader_cfg.svh"

// ==================================================
// Ring and scoreboard bookkeeping types
// ==================================================

package ring_pkg;

    // Slot index in the host ring.  The ring is a power of two long,
    // so the index wraps from the last slot to the first on its own
    typedef logic [`RR_RING_IDX_BITS-1:0] ring_idx_t;

    // Slot index in the reorder scoreboard
    localparam int SB_IDX_BITS = $clog2(`RR_SB_ENTRIES);
    typedef logic [SB_IDX_BITS-1:0] sb_idx_t;

endpackage

/* verilog/ring_read_requester.sv */
`timescale 1ns/1ps
`include "ring_reader_cfg.svh"

module ring_read_requester
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  mem_if_pkg::line_addr_t  ring_base,
    input  ring_pkg::ring_idx_t     newest_idx,
    input  logic                    sb_slot_free,
    input  ring_pkg::sb_idx_t       sb_slot_idx,
    input  logic                    read_grant,
    output logic                    read_req,
    output mem_if_pkg::line_addr_t  read_addr,
    output mem_if_pkg::read_mdata_t read_mdata
);

    import mem_if_pkg::*;
    import ring_pkg::*;

    // Index of the next ring slot to be read
    ring_idx_t next_idx;

    // The ring index zero-extended to the width of an address
    line_addr_t ring_offset;

    // ==================================================
    // Request generation
    // ==================================================

    // Ask for a line while the host has published slots that have not
    // been requested yet and the scoreboard has a slot to hold the reply
    assign read_req = (next_idx != newest_idx) && sb_slot_free;

    assign ring_offset = {{(`RR_ADDR_BITS - `RR_RING_IDX_BITS){1'b0}}, next_idx};

    // Adding the offset rather than replacing low address bits means the
    // ring does not have to be aligned to its own size in host memory
    assign read_addr = ring_base + ring_offset;

    always_comb
    begin
        // Every request from this block is a data read.  The slot the
        // scoreboard offers now is the one a grant will allocate
        read_mdata           = '0;
        read_mdata.is_header = 1'b0;
        read_mdata.rob_tag   = sb_slot_idx;
    end

    // ==================================================
    // Next-request index
    // ==================================================

    // A grant accepts the request in the same cycle, so the index moves
    // on at the edge that ends the granted cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            next_idx <= '0;
        end
        else if (read_grant)
        begin
            // Wraps past the last ring slot
            next_idx <= next_idx + 1'b1;
        end
    end

endmodule

/* verilog/reorder_scoreboard.sv */
`timescale 1ns/1ps
`include "ring_reader_cfg.svh"

module reorder_scoreboard
#(
    // Payload held in each slot.  Other response types can be reordered
    // by the same block
    parameter type payload_t = mem_if_pkg::line_data_t
)
(
    input  logic              clk,
    input  logic              reset_n,

    // Allocation, in request order
    input  logic              alloc_en,
    output logic              slot_free,
    output ring_pkg::sb_idx_t slot_idx,

    // Fill, in any order
    input  logic              fill_en,
    input  ring_pkg::sb_idx_t fill_idx,
    input  payload_t          fill_data,

    // Release, in allocation order
    input  logic              deq_en,
    output logic              head_valid,
    output payload_t          head_data
);

    import ring_pkg::*;

    localparam int N_ENTRIES = `RR_SB_ENTRIES;
    localparam int CNT_BITS  = $clog2(N_ENTRIES + 1);

    typedef logic [CNT_BITS-1:0] count_t;

    localparam count_t FULL_COUNT = count_t'(N_ENTRIES);

    // Next slot handed out to a request
    sb_idx_t alloc_ptr;

    // Oldest allocated slot, the head of the buffer
    sb_idx_t rel_ptr;

    // Slots allocated and not yet released
    count_t  count;

    // Set once the response for a slot has been written
    logic [N_ENTRIES-1:0] filled;

    // Response storage, indexed by slot
    payload_t slot_data [N_ENTRIES];

    // ==================================================
    // Status toward requester and output queue
    // ==================================================

    assign slot_free = (count != FULL_COUNT);
    assign slot_idx  = alloc_ptr;

    // The head may leave only when its own response has arrived,
    // even if younger slots were filled earlier
    assign head_valid = filled[rel_ptr];
    assign head_data  = slot_data[rel_ptr];

    // ==================================================
    // Pointers and occupancy
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
            count     <= '0;
        end
        else
        begin
            // Slot depth is a power of two, so the pointers wrap by themselves
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (deq_en)
            begin
                rel_ptr <= rel_ptr + 1'b1;
            end

            // Allocate and release in the same cycle leave the count alone
            case ({alloc_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==================================================
    // Fill tracking and storage
    // ==================================================

    // A fill at one edge shows as a valid slot after that edge.  A slot
    // being released is already filled, so fill and release never touch
    // the same bit in one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filled <= '0;
        end
        else
        begin
            if (fill_en)
            begin
                filled[fill_idx] <= 1'b1;
            end

            if (deq_en)
            begin
                filled[rel_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            slot_data[fill_idx] <= fill_data;
        end
    end

endmodule

/* verilog/line_out_queue.sv */
`timescale 1ns/1ps
`include "ring_reader_cfg.svh"

module line_out_queue
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   head_valid,
    input  mem_if_pkg::line_data_t head_data,
    output logic                   deq_head,
    output mem_if_pkg::line_data_t out_data,
    output logic                   out_valid,
    input  logic                   out_enable,
    output ring_pkg::ring_idx_t    oldest_idx
);

    import mem_if_pkg::*;

    // Two registered entries keep the client side off the scoreboard paths
    line_data_t entry [2];
    logic       wr_sel;
    logic       rd_sel;
    logic [1:0] fill_count;

    // ==================================================
    // FIFO control
    // ==================================================

    // Pull from the scoreboard whenever a line is ready and there is room
    assign deq_head  = head_valid && !fill_count[1];
    assign out_valid = (fill_count != 2'd0);
    assign out_data  = entry[rd_sel];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_sel     <= 1'b0;
            rd_sel     <= 1'b0;
            fill_count <= 2'd0;
            oldest_idx <= '0;
        end
        else
        begin
            if (deq_head)
            begin
                wr_sel <= ~wr_sel;

                // Lines leave the scoreboard in ring order, so counting them
                // here tracks the oldest slot the host may not yet reuse
                oldest_idx <= oldest_idx + `RR_RING_IDX_BITS'(1);
            end

            if (out_enable)
            begin
                rd_sel <= ~rd_sel;
            end

            // Push and pop together keep the level
            case ({deq_head, out_enable})
                2'b10:   fill_count <= fill_count + 2'd1;
                2'b01:   fill_count <= fill_count - 2'd1;
                default: fill_count <= fill_count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (deq_head)
        begin
            entry[wr_sel] <= head_data;
        end
    end

endmodule

/* verilog/ring_reader.sv */
`timescale 1ns/1ps
`include "ring_reader_cfg.svh"

module ring_reader
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Read requests toward host memory
    output logic                    read_req,
    output mem_if_pkg::line_addr_t  read_addr,
    output mem_if_pkg::read_mdata_t read_mdata,
    input  logic                    read_grant,

    // Read responses from host memory
    input  logic                    rsp_valid,
    input  mem_if_pkg::read_mdata_t rsp_mdata,
    input  mem_if_pkg::line_data_t  rsp_data,

    // FPGA-side client
    output mem_if_pkg::line_data_t  out_data,
    output logic                    out_valid,
    input  logic                    out_enable,

    // Ring indices exchanged with the host status path
    input  ring_pkg::ring_idx_t     newest_idx,
    output ring_pkg::ring_idx_t     oldest_idx,
    input  mem_if_pkg::line_addr_t  ring_base
);

    import mem_if_pkg::*;
    import ring_pkg::*;

    logic       sb_slot_free;
    sb_idx_t    sb_slot_idx;
    logic       sb_head_valid;
    line_data_t sb_head_data;
    logic       deq_en;
    logic       fill_en;

    // Responses flagged as header traffic belong to another client
    assign fill_en = rsp_valid && !rsp_mdata.is_header;

    // ==================================================
    // Requester, scoreboard and output queue
    // ==================================================

    ring_read_requester requester0
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .ring_base    (ring_base),
        .newest_idx   (newest_idx),
        .sb_slot_free (sb_slot_free),
        .sb_slot_idx  (sb_slot_idx),
        .read_grant   (read_grant),
        .read_req     (read_req),
        .read_addr    (read_addr),
        .read_mdata   (read_mdata)
    );

    // The grant also allocates the slot that was offered in the request tag
    reorder_scoreboard #(.payload_t(line_data_t)) scoreboard0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc_en   (read_grant),
        .slot_free  (sb_slot_free),
        .slot_idx   (sb_slot_idx),
        .fill_en    (fill_en),
        .fill_idx   (sb_idx_t'(rsp_mdata.rob_tag)),
        .fill_data  (rsp_data),
        .deq_en     (deq_en),
        .head_valid (sb_head_valid),
        .head_data  (sb_head_data)
    );

    line_out_queue out_queue0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .head_valid (sb_head_valid),
        .head_data  (sb_head_data),
        .deq_head   (deq_en),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_enable (out_enable),
        .oldest_idx (oldest_idx)
    );

endmodule

/* testbench/ring_reader_tb.sv */
`timescale 1ns/1ps
`include "ring_reader_cfg.svh"

module ring_reader_tb;

    import mem_if_pkg::*;
    import ring_pkg::*;

    localparam int RING_SLOTS  = 1 << `RR_RING_IDX_BITS;
    localparam int STALL_LIMIT = `RR_SB_ENTRIES + 2;
    localparam int WAIT_LIMIT  = 4000;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        read_req;
    line_addr_t  read_addr;
    read_mdata_t read_mdata;
    logic        read_grant;
    logic        rsp_valid;
    read_mdata_t rsp_mdata;
    line_data_t  rsp_data;
    line_data_t  out_data;
    logic        out_valid;
    logic        out_enable;
    ring_idx_t   newest_idx;
    ring_idx_t   oldest_idx;
    line_addr_t  ring_base;

    // Host side state, written by the test sequence and applied on the falling edge
    ring_idx_t   host_newest;
    line_addr_t  host_base;
    bit          pop_enable;
    bit          header_inject;

    // DUT outputs as seen on the falling edge, before any input moves
    logic        s_read_req;
    line_addr_t  s_read_addr;
    read_mdata_t s_read_mdata;
    logic        s_out_valid;
    line_data_t  s_out_data;
    ring_idx_t   s_oldest;

    // Outstanding reads in the memory model
    line_addr_t  pend_addr [$];
    sb_idx_t     pend_tag [$];
    int          pend_delay [$];

    integer      seed;
    int          reset_cycles;
    int          grants;
    int          delivered;
    int          issued;
    int          headers_sent;
    int          errors;
    int          checks;
    int          tests_run;
    bit          timed_out;

    ring_reader dut0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_req   (read_req),
        .read_addr  (read_addr),
        .read_mdata (read_mdata),
        .read_grant (read_grant),
        .rsp_valid  (rsp_valid),
        .rsp_mdata  (rsp_mdata),
        .rsp_data   (rsp_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_enable (out_enable),
        .newest_idx (newest_idx),
        .oldest_idx (oldest_idx),
        .ring_base  (ring_base)
    );

    always #2 clk = ~clk;

    // ==================================================
    // Reference model and helpers
    // ==================================================

    // Every line of host memory is a mix of its own address bits
    function automatic line_data_t line_at(input line_addr_t addr);
        return {addr ^ 32'ha5c3_0f96, addr * 32'h9e37_79b9};
    endfunction

    // Address of the n-th ring read since reset
    function automatic line_addr_t ring_addr(input int n);
        return host_base + line_addr_t'(n % RING_SLOTS);
    endfunction

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_that(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("FAILED at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (timed_out)
            $display("test %s: timed out", name);
        else if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // ==================================================
    // Memory model and client on the falling edge
    // ==================================================

    task automatic serve_memory();
        int ready_idx [$];
        int pick;
        int i;
        for (i = 0; i < pend_delay.size(); i++)
        begin
            if (pend_delay[i] > 0)
                pend_delay[i]--;
            if (pend_delay[i] == 0)
                ready_idx.push_back(i);
        end
        rsp_valid = 1'b0;
        rsp_mdata = '0;
        rsp_data  = '0;
        // Any ready read may answer, which shuffles the return order
        if (ready_idx.size() > 0 && rnd(4) != 0)
        begin
            pick = ready_idx[rnd(ready_idx.size())];
            rsp_valid         = 1'b1;
            rsp_mdata.rob_tag = pend_tag[pick];
            rsp_data          = line_at(pend_addr[pick]);
            pend_addr.delete(pick);
            pend_tag.delete(pick);
            pend_delay.delete(pick);
        end
        else if (header_inject && rnd(3) == 0)
        begin
            // Stray traffic for another client, with a tag that may alias a live slot
            rsp_valid           = 1'b1;
            rsp_mdata.is_header = 1'b1;
            rsp_mdata.rob_tag   = sb_idx_t'(rnd(`RR_SB_ENTRIES));
            rsp_data            = {$random(seed), $random(seed)};
            headers_sent++;
        end
        read_grant = 1'b0;
        if (s_read_req && rnd(4) != 0)
        begin
            read_grant = 1'b1;
            check_that(s_read_addr == ring_addr(grants),
                $sformatf("read %0d at %h, expected %h", grants, s_read_addr, ring_addr(grants)));
            check_that(!s_read_mdata.is_header && s_read_mdata.rob_tag == grants % `RR_SB_ENTRIES,
                $sformatf("read %0d carries wrong metadata %h", grants, s_read_mdata));
            pend_addr.push_back(s_read_addr);
            pend_tag.push_back(s_read_mdata.rob_tag);
            pend_delay.push_back(1 + rnd(12));
            grants++;
        end
    endtask

    task automatic serve_client();
        line_data_t expected;
        out_enable = 1'b0;
        if (pop_enable && s_out_valid && rnd(4) != 0)
        begin
            out_enable = 1'b1;
            expected   = line_at(ring_addr(delivered));
            check_that(delivered < grants, "a line came out that was never read");
            check_that(s_out_data == expected,
                $sformatf("line %0d is %h, expected %h", delivered, s_out_data, expected));
            delivered++;
        end
    endtask

    always @(negedge clk)
    begin
        s_read_req   = read_req;
        s_read_addr  = read_addr;
        s_read_mdata = read_mdata;
        s_out_valid  = out_valid;
        s_out_data   = out_data;
        s_oldest     = oldest_idx;
        if (reset_cycles < 5)
        begin
            reset_cycles++;
            if (reset_cycles == 5)
                reset_n = 1'b1;
        end
        else
        begin
            serve_memory();
            serve_client();
        end
        newest_idx = host_newest;
        ring_base  = host_base;
    end

    // ==================================================
    // Waits with their own timeouts
    // ==================================================

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (!reset_n && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!reset_n)
        begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_idle(input int target);
        int cycles;
        cycles = 0;
        while (!(delivered == target && !s_out_valid && pend_delay.size() == 0)
               && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!(delivered == target && !s_out_valid && pend_delay.size() == 0))
        begin
            $display("timeout: only %0d of %0d lines were delivered", delivered, target);
            timed_out = 1'b1;
        end
    endtask

    // The stall has settled once no read is asked for or outstanding for a few cycles
    task automatic wait_stalled();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < 4 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
            if (!s_read_req && pend_delay.size() == 0 && s_out_valid)
                quiet++;
            else
                quiet = 0;
        end
        if (quiet < 4)
        begin
            $display("timeout: reads kept flowing while the client was stalled");
            timed_out = 1'b1;
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic run_batch(input int k);
        host_newest = host_newest + ring_idx_t'(k);
        issued      = issued + k;
        wait_idle(issued);
        if (!timed_out)
        begin
            check_that(grants == issued, $sformatf("%0d reads for %0d slots", grants, issued));
            check_that(!s_read_req, "read_req still high with no unread slot");
            check_that(s_oldest == ring_idx_t'(issued % RING_SLOTS),
                $sformatf("oldest_idx is %0d after %0d lines", s_oldest, issued));
        end
    endtask

    task automatic run_backpressure_test();
        int e0;
        int g0;
        e0 = errors;
        g0 = grants;
        pop_enable  = 1'b0;
        host_newest = host_newest + ring_idx_t'(15);
        issued      = issued + 15;
        wait_stalled();
        if (!timed_out)
        begin
            check_that(grants - g0 <= STALL_LIMIT,
                $sformatf("%0d reads granted into a stalled client", grants - g0));
            // The oldest undelivered line must wait at the output unchanged
            check_that(s_out_data == line_at(ring_addr(delivered)),
                $sformatf("line %0d held as %h during the stall", delivered, s_out_data));
            pop_enable = 1'b1;
            wait_idle(issued);
            check_that(grants == issued, "reads did not resume after the stall");
        end
        report_test("back-pressure", e0);
    endtask

    initial
    begin
        int e0;
        seed          = 32'h3d1d_3d28;
        reset_n       = 1'b0;
        read_grant    = 1'b0;
        rsp_valid     = 1'b0;
        rsp_mdata     = '0;
        rsp_data      = '0;
        out_enable    = 1'b0;
        newest_idx    = '0;
        ring_base     = '0;
        host_newest   = '0;
        host_base     = 32'h0000_1000;
        pop_enable    = 1'b1;
        header_inject = 1'b0;
        reset_cycles  = 0;
        grants        = 0;
        delivered     = 0;
        issued        = 0;
        headers_sent  = 0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        timed_out     = 1'b0;

        e0 = errors;
        wait_reset_done();
        if (!timed_out)
        begin
            @(posedge clk);
            @(posedge clk);
            check_that(!s_read_req && !s_out_valid && s_oldest == '0, "outputs not idle after reset");
        end
        report_test("reset", e0);

        if (!timed_out)
        begin
            e0 = errors;
            run_batch(6);
            report_test("in-order delivery", e0);
        end

        // A base that is not aligned to the ring, and enough lines to wrap the index
        if (!timed_out)
        begin
            e0 = errors;
            host_base = 32'h0000_2345;
            run_batch(7);
            if (!timed_out)
                run_batch(7);
            if (!timed_out)
                run_batch(7);
            report_test("ring wrap", e0);
        end

        if (!timed_out)
        begin
            e0 = errors;
            header_inject = 1'b1;
            run_batch(10);
            header_inject = 1'b0;
            check_that(headers_sent > 0, "no header response was injected");
            report_test("header filtering", e0);
        end

        if (!timed_out)
            run_backpressure_test();

        if (!timed_out)
        begin
            e0 = errors;
            check_that(s_oldest == ring_idx_t'(issued % RING_SLOTS),
                $sformatf("oldest_idx is %0d after %0d lines", s_oldest, issued));
            report_test("oldest index", e0);
        end

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* ring_reader.f */
+incdir+verilog
verilog/mem_if_pkg.sv
verilog/ring_pkg.sv
verilog/ring_read_requester.sv
verilog/reorder_scoreboard.sv
verilog/line_out_queue.sv
verilog/ring_reader.sv
testbench/ring_reader_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ring_reader_tb
RTL_TOP    = ring_reader
FILE_LIST  = ring_reader.f
OBJ_DIR    = obj_dir
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
